// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Datapath widths
    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 6;
    localparam int IMM_W       = 10;
    // Register file depth, one per 6-bit index
    localparam int NUM_REGS    = 64;
    // Internal data RAM, word addressed
    localparam int DMEM_ADDR_W = 4;
    localparam int DMEM_WORDS  = 16;

    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [IMM_W-1:0]       imm_t;
    typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

    // Top nibble of the instruction word
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LW   = 4'h7,
        OP_SW   = 4'h8
    } opcode_t;

    // opcode | rd | rs | rt | imm, 4 + 6 + 6 + 6 + 10 bits
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        imm_t      imm;
    } instr_t;

    // Immediate is two's complement
    function automatic data_t sext_imm(imm_t imm);
        return {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

endpackage

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // ALU operand source, same codes as the forwarder
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_t;

    // Writeback source, RD is load data
    typedef enum logic [1:0] {
        SEL_RESULT_ALU = 2'b00,
        SEL_RESULT_RD  = 2'b01
    } result_sel_t;

    typedef struct packed {
        logic        rf_we;
        logic        mem_we;
        result_sel_t sel_result;
        opcode_t     alu_op;
        logic        use_imm;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t wa;
        data_t     rd_a;
        data_t     rd_b;
        imm_t      imm;
    } de_reg_t;

    // Execute to memory
    typedef struct packed {
        logic        valid;
        logic        rf_we;
        logic        mem_we;
        result_sel_t sel_result;
        reg_addr_t   wa;
        data_t       alu_out;
        data_t       store_data;
    } em_reg_t;

    // Memory to writeback
    typedef struct packed {
        logic      valid;
        logic      rf_we;
        reg_addr_t wa;
        data_t     result;
    } mw_reg_t;

    // Retired register write, seen outside the core
    typedef struct packed {
        reg_addr_t addr;
        data_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import isa_pkg::*; (
    input  wire            clk,
    input  wire            arst_n,
    input  wire reg_addr_t rd_addr_a,
    input  wire reg_addr_t rd_addr_b,
    output data_t          rd_data_a,
    output data_t          rd_data_b,
    input  wire            we,
    input  wire reg_addr_t wa,
    input  wire data_t     wd
);

    data_t regs [NUM_REGS];

    // r0 reads zero, a write in flight is passed straight through
    function automatic data_t read_port(reg_addr_t ra, data_t stored, logic w_en,
                                        reg_addr_t w_addr, data_t w_data);
        if (ra == '0) begin
            return '0;
        end
        if (w_en && (w_addr == ra)) begin
            return w_data;
        end
        return stored;
    endfunction

    assign rd_data_a = read_port(rd_addr_a, regs[rd_addr_a], we, wa, wd);
    assign rd_data_b = read_port(rd_addr_b, regs[rd_addr_b], we, wa, wd);

    // Writes to r0 dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire            clk,
    input  wire            arst_n,
    input  wire            in_valid,
    input  wire instr_t    in_instr,
    output logic           in_ready,
    input  wire            d_stall,
    output reg_addr_t      rd_addr_a,
    output reg_addr_t      rd_addr_b,
    input  wire data_t     rd_data_a,
    input  wire data_t     rd_data_b,
    output reg_addr_t      d_rs,
    output reg_addr_t      d_rt,
    output de_reg_t        de
);

    logic    ir_valid;
    instr_t  ir;
    ctrl_t   ctrl;
    logic    uses_rs;
    logic    uses_rt;
    de_reg_t de_next;

    // Input held off only by a load-use stall
    assign in_ready = !d_stall;

    // Instruction register, frozen while stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir_valid <= 1'b0;
        end else if (in_ready) begin
            ir_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            ir <= in_instr;
        end
    end

    // Control decode
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = OP_ADD;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        case (ir.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                ctrl.rf_we  = 1'b1;
                ctrl.alu_op = ir.opcode;
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
            end
            OP_ADDI: begin
                ctrl.rf_we   = 1'b1;
                ctrl.use_imm = 1'b1;
                uses_rs      = 1'b1;
            end
            // Address is rs + imm
            OP_LW: begin
                ctrl.rf_we      = 1'b1;
                ctrl.use_imm    = 1'b1;
                ctrl.sel_result = SEL_RESULT_RD;
                uses_rs         = 1'b1;
            end
            // rt carries the store data
            OP_SW: begin
                ctrl.mem_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                uses_rs      = 1'b1;
                uses_rt      = 1'b1;
            end
            default: begin
            end
        endcase
        // r0 never takes a result
        if (ir.rd == '0) begin
            ctrl.rf_we = 1'b0;
        end
    end

    // Source fields zeroed when unread, so they never match a hazard
    assign d_rs      = (ir_valid && uses_rs) ? ir.rs : '0;
    assign d_rt      = (ir_valid && uses_rt) ? ir.rt : '0;
    assign rd_addr_a = ir.rs;
    assign rd_addr_b = ir.rt;

    always_comb begin
        de_next.valid = 1'b1;
        de_next.ctrl  = ctrl;
        de_next.rs    = d_rs;
        de_next.rt    = d_rt;
        de_next.wa    = ir.rd;
        de_next.rd_a  = rd_data_a;
        de_next.rd_b  = rd_data_b;
        de_next.imm   = ir.imm;
    end

    // Bubble into execute when idle or while the stall holds this instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de <= '0;
        end else if (!ir_valid || d_stall) begin
            de <= '0;
        end else begin
            de <= de_next;
        end
    end

    // Input blocked during a stall, and a stall never repeats
    assert property (@(posedge clk) disable iff (!arst_n)
        d_stall |-> !in_ready ##1 !d_stall);

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire           clk,
    input  wire           arst_n,
    input  wire de_reg_t  de,
    input  wire           e_flush,
    input  wire fwd_sel_t fwd_a,
    input  wire fwd_sel_t fwd_b,
    input  wire mw_reg_t  mw,
    output em_reg_t       em
);

    data_t   op_a;
    data_t   op_b;
    data_t   alu_b;
    data_t   alu_out;
    em_reg_t em_next;

    // Operand source, register file value unless a newer result is in flight
    function automatic data_t fwd_mux(fwd_sel_t sel, data_t rf_val, data_t mem_val,
                                      data_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a, de.rd_a, em.alu_out, mw.result);
    assign op_b = fwd_mux(fwd_b, de.rd_b, em.alu_out, mw.result);

    // ADDI, LW and SW add the immediate
    assign alu_b = de.ctrl.use_imm ? sext_imm(de.imm) : op_b;

    always_comb begin
        case (de.ctrl.alu_op)
            OP_SUB:  alu_out = op_a - alu_b;
            OP_AND:  alu_out = op_a & alu_b;
            OP_OR:   alu_out = op_a | alu_b;
            OP_XOR:  alu_out = op_a ^ alu_b;
            default: alu_out = op_a + alu_b;
        endcase
    end

    always_comb begin
        em_next.valid      = de.valid;
        em_next.rf_we      = de.valid && de.ctrl.rf_we;
        em_next.mem_we     = de.valid && de.ctrl.mem_we;
        em_next.sel_result = de.ctrl.sel_result;
        em_next.wa         = de.wa;
        em_next.alu_out    = alu_out;
        // Store data after forwarding
        em_next.store_data = op_b;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            em <= '0;
        end else begin
            em <= em_next;
        end
    end

    // Memory forwarding needs a live instruction in memory
    assert property (@(posedge clk) disable iff (!arst_n)
        (fwd_a == FWD_MEM) |-> em.valid);

    // The load behind a flush moves on into memory
    assert property (@(posedge clk) disable iff (!arst_n)
        e_flush |=> em.valid && (em.sel_result == SEL_RESULT_RD));

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire          clk,
    input  wire          arst_n,
    input  wire em_reg_t em,
    output mw_reg_t      mw
);

    data_t      ram [DMEM_WORDS];
    dmem_addr_t addr;
    data_t      rd_word;
    data_t      result;
    mw_reg_t    mw_next;

    // Word address from the low bits of the ALU sum
    assign addr = em.alu_out[DMEM_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (em.mem_we) begin
            ram[addr] <= em.store_data;
        end
    end

    // Asynchronous read, load data in the same cycle
    assign rd_word = ram[addr];
    assign result  = (em.sel_result == SEL_RESULT_RD) ? rd_word : em.alu_out;

    always_comb begin
        mw_next.valid  = em.valid;
        mw_next.rf_we  = em.rf_we;
        mw_next.wa     = em.wa;
        mw_next.result = result;
    end

    // Writeback register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mw <= '0;
        end else begin
            mw <= mw_next;
        end
    end

    // Stores never write a register
    assert property (@(posedge clk) disable iff (!arst_n)
        !(em.mem_we && em.rf_we));

endmodule

`default_nettype wire

// File: design/hazard_controller.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_controller import isa_pkg::*, pipe_pkg::*; (
    input  wire reg_addr_t d_rs,
    input  wire reg_addr_t d_rt,
    input  wire de_reg_t   de,
    input  wire em_reg_t   em,
    input  wire mw_reg_t   mw,
    output fwd_sel_t       fwd_a,
    output fwd_sel_t       fwd_b,
    output logic           d_stall,
    output logic           e_flush
);

    logic load_use;

    // Nearest writer wins, memory before writeback
    function automatic fwd_sel_t fwd_select(reg_addr_t src, em_reg_t m, mw_reg_t w);
        if ((src != '0) && (src == m.wa) && m.rf_we) begin
            return FWD_MEM;
        end else if ((src != '0) && (src == w.wa) && w.rf_we) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    // Sources of the instruction now in execute
    assign fwd_a = fwd_select(de.rs, em, mw);
    assign fwd_b = fwd_select(de.rt, em, mw);

    // Load in execute feeding the instruction in decode
    // rf_we already excludes r0 as a destination
    assign load_use = de.valid && de.ctrl.rf_we
                   && (de.ctrl.sel_result == SEL_RESULT_RD)
                   && ((de.wa == d_rs) || (de.wa == d_rt));

    // Hold decode and send a bubble into execute together
    assign d_stall = load_use;
    assign e_flush = load_use;

    always_comb begin
        stall_flush_pair : assert final (d_stall == e_flush);
    end

endmodule

`default_nettype wire

// File: design/pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core import isa_pkg::*, pipe_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         in_valid,
    input  wire instr_t in_instr,
    output logic        in_ready,
    output logic        wb_valid,
    output wb_t         wb
);

    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    data_t     rd_data_a;
    data_t     rd_data_b;
    reg_addr_t d_rs;
    reg_addr_t d_rt;
    de_reg_t   de;
    em_reg_t   em;
    mw_reg_t   mw;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    logic      d_stall;
    logic      e_flush;
    logic      rf_we;

    // Retiring register write
    assign rf_we = mw.valid && mw.rf_we;

    decode_stage u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_ready  (in_ready),
        .d_stall   (d_stall),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .d_rs      (d_rs),
        .d_rt      (d_rt),
        .de        (de)
    );

    execute_stage u_execute (
        .clk     (clk),
        .arst_n  (arst_n),
        .de      (de),
        .e_flush (e_flush),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .mw      (mw),
        .em      (em)
    );

    mem_stage u_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .em     (em),
        .mw     (mw)
    );

    regfile u_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .we        (rf_we),
        .wa        (mw.wa),
        .wd        (mw.result)
    );

    hazard_controller u_hazard (
        .d_rs    (d_rs),
        .d_rt    (d_rt),
        .de      (de),
        .em      (em),
        .mw      (mw),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .d_stall (d_stall),
        .e_flush (e_flush)
    );

    // Writeback stream straight off the writeback register
    assign wb_valid = rf_we;
    assign wb       = '{addr: mw.wa, data: mw.result};

endmodule

`default_nettype wire

// File: testbench/tb_pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_core import isa_pkg::*, pipe_pkg::*; ();

    localparam int SEND_TIMEOUT  = 20;
    localparam int DRAIN_TIMEOUT = 50;
    localparam int WB_LATENCY    = 4;
    localparam int RANDOM_COUNT  = 200;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    instr_t      in_instr;
    logic        in_ready;
    logic        wb_valid;
    wb_t         wb;

    // Architectural reference state
    data_t       model_regs [NUM_REGS];
    data_t       model_mem [DMEM_WORDS];
    bit          mem_written [DMEM_WORDS];
    // Expected records and their acceptance edges in program order
    wb_t         exp_q [$];
    int          acc_q [$];
    int          cyc;
    bit          lat_check_en;
    int          retired;
    logic [31:0] lcg_state;
    wb_t         head_rec;
    int          head_cyc;

    pipe_core i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_ready (in_ready),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    always #10 clk = ~clk;

    // Rising edges since reset release
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_wb(input wb_t act, input wb_t exp);
        if (act.addr !== exp.addr) begin
            $display("[ERROR] wb.addr: got 0x%h, expected 0x%h", act.addr, exp.addr);
            stop_with_failure("Writeback record went to the wrong register");
        end
        if (act.data !== exp.data) begin
            $display("[ERROR] wb.data: got 0x%h, expected 0x%h", act.data, exp.data);
            stop_with_failure("Writeback record carries the wrong value");
        end
    endtask

    task automatic check_ready(input logic act, input logic exp);
        if (act !== exp) begin
            $display("[ERROR] in_ready: got 0x%h, expected 0x%h", act, exp);
            stop_with_failure("Input handshake in the wrong state");
        end
    endtask

    task automatic check_latency(input int act, input int exp);
        if (act != exp) begin
            $display("[ERROR] wb latency: got 0x%h, expected 0x%h", act, exp);
            stop_with_failure("Writeback arrived at the wrong cycle");
        end
    endtask

    // Fixed-seed LCG returning its upper bits
    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % n;
    endfunction

    function automatic data_t sign_extend(input imm_t imm);
        data_t ext;
        ext = {{(DATA_W-IMM_W){1'b0}}, imm};
        if (imm[IMM_W-1]) begin
            ext[DATA_W-1:IMM_W] = '1;
        end
        return ext;
    endfunction

    function automatic instr_t encode(input opcode_t op, input int rd, input int rs,
                                      input int rt, input int imm);
        instr_t ins;
        ins.opcode = op;
        ins.rd     = reg_addr_t'(rd);
        ins.rs     = reg_addr_t'(rs);
        ins.rt     = reg_addr_t'(rt);
        ins.imm    = imm_t'(imm);
        return ins;
    endfunction

    // Executes one accepted instruction and queues its record
    task automatic model_execute(input instr_t ins);
        data_t      a;
        data_t      b;
        data_t      res;
        dmem_addr_t addr;
        logic       writes;
        wb_t        rec;
        a      = (ins.rs == '0) ? '0 : model_regs[ins.rs];
        b      = (ins.rt == '0) ? '0 : model_regs[ins.rt];
        res    = '0;
        writes = 1'b1;
        // Word address wraps in the 16-word RAM
        addr   = dmem_addr_t'(a + sign_extend(ins.imm));
        case (ins.opcode)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + sign_extend(ins.imm);
            OP_LW: begin
                if (!mem_written[addr]) begin
                    stop_with_failure("Test program loads a data word never stored");
                end
                res = model_mem[addr];
            end
            OP_SW: begin
                model_mem[addr]   = b;
                mem_written[addr] = 1'b1;
                writes            = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && (ins.rd != '0)) begin
            model_regs[ins.rd] = res;
            rec.addr = ins.rd;
            rec.data = res;
            exp_q.push_back(rec);
            // Accepted at the coming edge
            acc_q.push_back(cyc + 1);
        end
    endtask

    // Runs from 1 ns after an edge to 1 ns after the accepting edge
    task automatic send_instr(input instr_t ins);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_instr = ins;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > SEND_TIMEOUT) begin
                stop_with_failure("Timeout waiting for in_ready");
            end
            @(negedge clk);
        end
        model_execute(ins);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            if (waited >= DRAIN_TIMEOUT) begin
                stop_with_failure("Timeout waiting for the expected writeback records");
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    // Writeback monitor sampling mid-cycle
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("Writeback record seen with none expected");
            end else begin
                head_rec = exp_q.pop_front();
                head_cyc = acc_q.pop_front();
                check_wb(wb, head_rec);
                if (lat_check_en) begin
                    check_latency(cyc - head_cyc + 1, WB_LATENCY);
                end
                retired++;
            end
        end
    end

    task automatic independent_ops();
        $display("Test: independent operations");
        lat_check_en = 1'b1;
        send_instr(encode(OP_ADDI, 1, 0, 0, 5));
        send_instr(encode(OP_ADDI, 2, 0, 0, -3));
        send_instr(encode(OP_ADDI, 3, 0, 0, 100));
        send_instr(encode(OP_ADDI, 4, 0, 0, 'h1ff));
        // Sources retired before use
        idle_cycles(4);
        send_instr(encode(OP_ADD, 5, 1, 2, 0));
        send_instr(encode(OP_SUB, 6, 3, 4, 0));
        send_instr(encode(OP_AND, 7, 4, 3, 0));
        idle_cycles(1);
        send_instr(encode(OP_OR, 8, 1, 4, 0));
        send_instr(encode(OP_XOR, 9, 2, 3, 0));
        wait_drain();
        lat_check_en = 1'b0;
    endtask

    task automatic forwarding_paths();
        $display("Test: forwarding");
        send_instr(encode(OP_ADDI, 10, 0, 0, 7));
        // Both operands from memory
        send_instr(encode(OP_ADD, 11, 10, 10, 0));
        // a from memory and b from writeback
        send_instr(encode(OP_SUB, 12, 11, 10, 0));
        // b from memory
        send_instr(encode(OP_SUB, 13, 10, 12, 0));
        // a from writeback and b from memory
        send_instr(encode(OP_ADD, 14, 12, 13, 0));
        send_instr(encode(OP_ADDI, 16, 0, 0, 9));
        send_instr(encode(OP_ADDI, 17, 0, 0, 1));
        // Both operands from writeback
        send_instr(encode(OP_ADD, 18, 16, 16, 0));
        send_instr(encode(OP_SUB, 19, 18, 17, 0));
        wait_drain();
    endtask

    task automatic load_use_stall();
        $display("Test: load-use stall");
        send_instr(encode(OP_ADDI, 20, 0, 0, 'h55));
        send_instr(encode(OP_SW, 0, 0, 20, 3));
        send_instr(encode(OP_LW, 21, 0, 0, 3));
        wait_drain();
        // Consumer on rs
        send_instr(encode(OP_LW, 22, 0, 0, 3));
        send_instr(encode(OP_ADD, 23, 22, 20, 0));
        @(negedge clk);
        check_ready(in_ready, 1'b0);
        @(negedge clk);
        check_ready(in_ready, 1'b1);
        idle_cycles(1);
        wait_drain();
        // Consumer on rt
        send_instr(encode(OP_LW, 26, 0, 0, 3));
        send_instr(encode(OP_SUB, 27, 20, 26, 0));
        @(negedge clk);
        check_ready(in_ready, 1'b0);
        @(negedge clk);
        check_ready(in_ready, 1'b1);
        idle_cycles(1);
        wait_drain();
        // Unrelated follower runs without a stall
        send_instr(encode(OP_LW, 24, 0, 0, 3));
        send_instr(encode(OP_ADDI, 25, 20, 0, 1));
        @(negedge clk);
        check_ready(in_ready, 1'b1);
        idle_cycles(1);
        wait_drain();
    endtask

    task automatic store_then_load();
        $display("Test: store then load");
        send_instr(encode(OP_ADDI, 30, 0, 0, 'h123));
        send_instr(encode(OP_ADDI, 31, 0, 0, 'h0ab));
        send_instr(encode(OP_SW, 0, 0, 30, 5));
        // Same word straight after the store
        send_instr(encode(OP_LW, 32, 0, 0, 5));
        send_instr(encode(OP_ADDI, 33, 0, 0, 4));
        send_instr(encode(OP_SW, 0, 33, 31, 2));
        // Other word and then the one just stored
        send_instr(encode(OP_LW, 34, 33, 0, 1));
        send_instr(encode(OP_LW, 35, 33, 0, 2));
        // Negative offset
        send_instr(encode(OP_LW, 36, 33, 0, -1));
        wait_drain();
    endtask

    task automatic register_zero();
        $display("Test: register 0");
        send_instr(encode(OP_ADDI, 0, 0, 0, 'h3f));
        send_instr(encode(OP_ADD, 0, 1, 2, 0));
        send_instr(encode(OP_LW, 0, 0, 0, 3));
        send_instr(encode(OP_ADDI, 40, 0, 0, 'h12));
        send_instr(encode(OP_ADD, 41, 0, 0, 0));
        // A write to r0 in flight is not forwarded
        send_instr(encode(OP_ADDI, 0, 1, 0, 5));
        send_instr(encode(OP_ADD, 42, 0, 1, 0));
        wait_drain();
    endtask

    task automatic random_programs();
        opcode_t op;
        int      rd;
        int      rs;
        int      rt;
        int      imm;
        $display("Test: random programs");
        // Every data word gets a defined value first
        for (int i = 0; i < DMEM_WORDS; i++) begin
            rt = 1 + int'(rand_below(7));
            send_instr(encode(OP_SW, 0, 0, rt, i));
        end
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            op  = opcode_t'(4'(rand_below(9)));
            // Few registers give many hazards
            rd  = int'(rand_below(8));
            rs  = int'(rand_below(8));
            rt  = int'(rand_below(8));
            imm = int'(rand_below(1024));
            send_instr(encode(op, rd, rs, rt, imm));
            if (rand_below(4) == 0) begin
                idle_cycles(1 + int'(rand_below(3)));
            end
        end
        wait_drain();
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        lcg_state    = 32'd89052;
        lat_check_en = 1'b0;
        retired      = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i]   = '0;
            mem_written[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_ready(in_ready, 1'b1);

        independent_ops();
        forwarding_paths();
        load_use_stall();
        store_then_load();
        register_zero();
        random_programs();

        // Nothing may retire after the last expected record
        idle_cycles(6);
        $display("Retired %0d register writes", retired);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/hazard_controller.sv
design/pipe_core.sv
testbench/tb_pipe_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipe_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
